// File: hw/pb_pkg.sv
package pb_pkg;

    // Serial bit timing
    localparam int clks_per_bit = 16;                 // Clock cycles per serial bit
    localparam int half_bit     = clks_per_bit / 2;   // Start bit to middle of bit
    localparam int tick_w       = $clog2(clks_per_bit);

    // Line and field sizes
    localparam int line_max     = 32;   // Longest stored line in bytes
    localparam int name_len     = 10;   // Comma sits right after the name
    localparam int param_digits = 8;    // Hex digits after the comma
    localparam int data_w       = 8;
    localparam int addr_w       = 3;
    localparam int board_w      = 4;

    // Bytes moved per command
    localparam int write_bytes = 2;
    localparam int read_bytes  = 4;

    // Access length is setup, strobe_cycles, release
    localparam int strobe_cycles = 2;

    localparam logic [7:0] char_lf    = 8'h0A;
    localparam logic [7:0] char_cr    = 8'h0D;
    localparam logic [7:0] char_comma = 8'h2C;

    localparam logic [7:0] err_unknown = 8'hFE;   // Name not recognised
    localparam logic [7:0] err_hex     = 8'hFD;   // Bad or missing hex digit

    // Command names and fixed reply text
    localparam logic [8*name_len-1:0] cmd_name_write = "pb_i_write";
    localparam logic [8*name_len-1:0] cmd_name_read  = "pb_i__read";
    localparam logic [23:0]           reply_ok       = ",OK";
    localparam logic [71:0]           reply_fail     = "Failed 0x";

    // Reply lengths including CR LF
    localparam int reply_max       = 21;
    localparam int reply_len_write = 15;
    localparam int reply_len_read  = 21;
    localparam int reply_len_fail  = 13;

    typedef enum logic [1:0] {
        cmd_write,
        cmd_read
    } cmd_e;

    // Parser fills bytes in arrival order, sequencer reads the fields
    typedef union packed {
        logic [0:3][7:0] bytes;
        struct packed {
            logic [7:0] addr;    // Low addr_w bits used
            logic [7:0] board;   // Low board_w bits used
            logic [7:0] data0;
            logic [7:0] data1;
        } fields;
    } param_u;

endpackage

// File: hw/uart_rx.sv
module uart_rx (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       serial_in,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    logic [1:0]                  sync;      // Two-stage synchroniser
    logic                        busy;
    logic [3:0]                  bit_idx;   // 0 start, 1..8 data, 9 stop
    logic [pb_pkg::tick_w-1:0]   tick;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            sync     <= 2'b11;
            busy     <= 1'b0;
            bit_idx  <= '0;
            tick     <= '0;
            rx_valid <= 1'b0;
        end else begin
            sync     <= {sync[0], serial_in};
            rx_valid <= 1'b0;
            if (!busy) begin
                if (!sync[1]) begin                                 // Falling edge of start bit
                    busy    <= 1'b1;
                    bit_idx <= '0;
                    tick    <= pb_pkg::tick_w'(pb_pkg::half_bit - 1);
                end
            end else if (tick != '0) begin
                tick <= tick - 1'b1;
            end else begin
                // Middle of the current bit
                tick    <= pb_pkg::tick_w'(pb_pkg::clks_per_bit - 1);
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 4'd0) begin
                    if (sync[1]) begin
                        busy <= 1'b0;                               // Glitch, not a start bit
                    end
                end else if (bit_idx == 4'd9) begin
                    busy     <= 1'b0;
                    rx_valid <= sync[1];                            // Drop frame on bad stop bit
                end else begin
                    rx_data <= {sync[1], rx_data[7:1]};             // LSB arrives first
                end
            end
        end
    end

endmodule

// File: hw/uart_tx.sv
module uart_tx (
    input  logic       clock,
    input  logic       rst_n,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       tx_busy,
    output logic       serial_out
);

    logic [8:0]                shift;       // Data bits then stop bit
    logic [3:0]                bits_left;
    logic [pb_pkg::tick_w-1:0] tick;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            tx_busy    <= 1'b0;
            serial_out <= 1'b1;          // Line idles high
            bits_left  <= '0;
            tick       <= '0;
        end else if (!tx_busy) begin
            serial_out <= 1'b1;
            if (tx_start) begin
                tx_busy    <= 1'b1;
                shift      <= {1'b1, tx_data};
                serial_out <= 1'b0;      // Start bit
                bits_left  <= 4'd9;
                tick       <= pb_pkg::tick_w'(pb_pkg::clks_per_bit - 1);
            end
        end else if (tick != '0) begin
            tick <= tick - 1'b1;
        end else if (bits_left != '0) begin
            serial_out <= shift[0];
            shift      <= {1'b1, shift[8:1]};
            bits_left  <= bits_left - 1'b1;
            tick       <= pb_pkg::tick_w'(pb_pkg::clks_per_bit - 1);
        end else begin
            tx_busy <= 1'b0;             // Stop bit fully sent
        end
    end

endmodule

// File: hw/command_parser.sv
module command_parser (
    input  logic           clock,
    input  logic           rst_n,
    input  logic [7:0]     rx_data,
    input  logic           rx_valid,
    input  logic           reply_busy,
    output logic           start,
    output pb_pkg::cmd_e   cmd,
    output pb_pkg::param_u param,
    output logic           fail,
    output logic [7:0]     fail_code
);

    logic [7:0]                            line_buf [pb_pkg::line_max];
    logic [$clog2(pb_pkg::line_max+1)-1:0] len;
    logic                                  decode;     // LF seen, decode next cycle
    logic                                  awaiting;   // Command issued, reply not begun

    logic [8*pb_pkg::name_len-1:0] name_word;
    logic                          is_write;
    logic                          is_read;
    logic                          hex_ok;
    logic [4:0]                    nib;
    pb_pkg::param_u                conv;

    // Returns {valid, value}, either letter case
    function automatic logic [4:0] hex_value(input logic [7:0] c);
        if (c >= "0" && c <= "9") begin
            return {1'b1, c[3:0]};
        end
        if ((c >= "A" && c <= "F") || (c >= "a" && c <= "f")) begin
            return {1'b1, c[3:0] + 4'd9};
        end
        return 5'b0;
    endfunction

    always_comb begin
        name_word = '0;
        for (int i = 0; i < pb_pkg::name_len; i++) begin
            name_word[(pb_pkg::name_len-1-i)*8 +: 8] = line_buf[i];
        end
        is_write = (name_word == pb_pkg::cmd_name_write) &&
                   (line_buf[pb_pkg::name_len] == pb_pkg::char_comma);
        is_read  = (name_word == pb_pkg::cmd_name_read) &&
                   (line_buf[pb_pkg::name_len] == pb_pkg::char_comma);

        hex_ok = int'(len) >= pb_pkg::name_len + 1 + pb_pkg::param_digits;   // Short line
        conv   = '0;
        nib    = '0;
        for (int d = 0; d < pb_pkg::param_digits; d++) begin
            nib    = hex_value(line_buf[pb_pkg::name_len + 1 + d]);
            hex_ok = hex_ok & nib[4];
            conv.bytes[d/2][4*(1-d%2) +: 4] = nib[3:0];   // Even digit is high nibble
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            len      <= '0;
            decode   <= 1'b0;
            awaiting <= 1'b0;
            start    <= 1'b0;
            fail     <= 1'b0;
        end else begin
            start  <= 1'b0;
            fail   <= 1'b0;
            decode <= 1'b0;
            if (reply_busy) begin
                awaiting <= 1'b0;            // Writer has taken over the back-pressure
            end
            if (rx_valid && !reply_busy && !awaiting && !decode) begin
                if (rx_data == pb_pkg::char_lf) begin
                    decode <= 1'b1;
                end else if (rx_data != pb_pkg::char_cr &&
                             int'(len) < pb_pkg::line_max) begin
                    line_buf[len[$clog2(pb_pkg::line_max)-1:0]] <= rx_data;
                    len <= len + 1'b1;
                end
            end
            if (decode) begin
                len      <= '0;
                awaiting <= 1'b1;
                if (!is_write && !is_read) begin
                    fail      <= 1'b1;
                    fail_code <= pb_pkg::err_unknown;
                end else if (!hex_ok) begin
                    fail      <= 1'b1;
                    fail_code <= pb_pkg::err_hex;
                end else begin
                    start <= 1'b1;
                    cmd   <= is_write ? pb_pkg::cmd_write : pb_pkg::cmd_read;
                    param <= conv;
                end
            end
        end
    end

endmodule

// File: hw/bus_sequencer.sv
module bus_sequencer (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       start,
    input  pb_pkg::cmd_e               cmd,
    input  pb_pkg::param_u             param,
    output logic                       done,
    output pb_pkg::cmd_e               done_cmd,
    output logic [31:0]                read_word,
    inout  wire [pb_pkg::data_w-1:0]   data_pins,
    output logic [pb_pkg::addr_w-1:0]  addr_pins,
    output logic [pb_pkg::board_w-1:0] board_sel,
    output logic                       rd,
    output logic                       wr,
    output logic                       level_shift_en
);

    logic                      active;
    logic [1:0]                phase;      // 0 setup, strobe, then release
    logic [1:0]                access;     // Byte number within the command
    pb_pkg::param_u            param_q;
    logic                      data_dir;   // High while we drive data_pins
    logic                      strobe;
    logic                      release_phase;
    logic                      last_access;
    logic [pb_pkg::data_w-1:0] out_byte;

    assign strobe        = active && phase >= 2'd1 && phase <= 2'(pb_pkg::strobe_cycles);
    assign release_phase = phase == 2'(pb_pkg::strobe_cycles + 1);
    assign last_access   = (done_cmd == pb_pkg::cmd_write) ?
                           (access == 2'(pb_pkg::write_bytes - 1)) :
                           (access == 2'(pb_pkg::read_bytes - 1));

    assign data_dir = active && done_cmd == pb_pkg::cmd_write;
    assign wr       = strobe && data_dir;
    assign rd       = strobe && !data_dir;
    assign done     = active && release_phase && last_access;

    // Address wraps modulo 8
    assign addr_pins = param_q.fields.addr[pb_pkg::addr_w-1:0] + access;
    assign board_sel = param_q.fields.board[pb_pkg::board_w-1:0];

    assign out_byte  = access[0] ? param_q.fields.data1 : param_q.fields.data0;
    assign data_pins = data_dir ? out_byte : 'z;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            active         <= 1'b0;
            phase          <= '0;
            access         <= '0;
            level_shift_en <= 1'b0;
        end else begin
            level_shift_en <= 1'b1;           // Enable buffers once out of reset
            if (!active) begin
                if (start) begin
                    active <= 1'b1;
                    phase  <= '0;
                    access <= '0;
                end
            end else begin
                phase <= phase + 1'b1;
                if (release_phase) begin
                    access <= access + 1'b1;
                    if (last_access) begin
                        active <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start && !active) begin
            done_cmd <= cmd;
            param_q  <= param;
        end
        // Sample in the second strobe cycle, first byte ends up on top
        if (rd && phase == 2'(pb_pkg::strobe_cycles)) begin
            read_word <= {read_word[23:0], data_pins};
        end
    end

endmodule

// File: hw/response_writer.sv
module response_writer (
    input  logic         clock,
    input  logic         rst_n,
    input  logic         done,
    input  pb_pkg::cmd_e done_cmd,
    input  logic [31:0]  read_word,
    input  logic         fail,
    input  logic [7:0]   fail_code,
    input  logic         tx_busy,
    output logic         tx_start,
    output logic [7:0]   tx_data,
    output logic         reply_busy
);

    logic [8*pb_pkg::reply_max-1:0] text;        // Left-aligned reply
    logic [8*pb_pkg::reply_max-1:0] next_text;
    logic [4:0]                     len;
    logic [4:0]                     next_len;
    logic [4:0]                     idx;

    // Upper-case hex
    function automatic logic [7:0] hex_char(input logic [3:0] n);
        return {4'h0, n} + ((n < 4'd10) ? 8'h30 : 8'h37);
    endfunction

    always_comb begin
        if (fail) begin
            next_text = {pb_pkg::reply_fail, hex_char(fail_code[7:4]), hex_char(fail_code[3:0]),
                         pb_pkg::char_cr, pb_pkg::char_lf, {8{8'h00}}};
            next_len  = 5'(pb_pkg::reply_len_fail);
        end else if (done_cmd == pb_pkg::cmd_write) begin
            next_text = {pb_pkg::cmd_name_write, pb_pkg::reply_ok,
                         pb_pkg::char_cr, pb_pkg::char_lf, {6{8'h00}}};
            next_len  = 5'(pb_pkg::reply_len_write);
        end else begin
            next_text = {pb_pkg::cmd_name_read, pb_pkg::char_comma, {8{8'h00}},
                         pb_pkg::char_cr, pb_pkg::char_lf};
            // Eight digits after the comma, top nibble first
            for (int i = 0; i < 8; i++) begin
                next_text[(pb_pkg::reply_max - 12 - i)*8 +: 8] = hex_char(read_word[(7-i)*4 +: 4]);
            end
            next_len  = 5'(pb_pkg::reply_len_read);
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            reply_busy <= 1'b0;
            tx_start   <= 1'b0;
            idx        <= '0;
        end else begin
            tx_start <= 1'b0;
            if (!reply_busy) begin
                if (done || fail) begin
                    reply_busy <= 1'b1;
                    idx        <= '0;
                end
            end else if (!tx_busy && !tx_start) begin   // tx_busy lags tx_start by a cycle
                tx_start <= 1'b1;
                idx      <= idx + 1'b1;
                if (idx == len - 1'b1) begin
                    reply_busy <= 1'b0;                 // Last byte handed over
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reply_busy && (done || fail)) begin
            text <= next_text;
            len  <= next_len;
        end
        if (reply_busy && !tx_busy && !tx_start) begin
            tx_data <= text[(pb_pkg::reply_max - 1 - int'(idx))*8 +: 8];
        end
    end

endmodule

// File: hw/pb_bridge_top.sv
module pb_bridge_top (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       uart_rx_pin,
    output logic                       uart_tx_pin,
    inout  wire [pb_pkg::data_w-1:0]   data_pins,
    output logic [pb_pkg::addr_w-1:0]  addr_pins,
    output logic [pb_pkg::board_w-1:0] board_sel,
    output logic                       rd,
    output logic                       wr,
    output logic                       level_shift_en
);

    logic [7:0]     rx_data;
    logic           rx_valid;
    logic           start;
    pb_pkg::cmd_e   cmd;
    pb_pkg::param_u param;
    logic           fail;
    logic [7:0]     fail_code;
    logic           done;
    pb_pkg::cmd_e   done_cmd;
    logic [31:0]    read_word;
    logic [7:0]     tx_data;
    logic           tx_start;
    logic           tx_busy;
    logic           reply_busy;

    uart_rx u_uart_rx (
        .clock(clock), .rst_n(rst_n), .serial_in(uart_rx_pin),
        .rx_data(rx_data), .rx_valid(rx_valid)
    );

    command_parser u_command_parser (
        .clock(clock), .rst_n(rst_n), .rx_data(rx_data), .rx_valid(rx_valid),
        .reply_busy(reply_busy), .start(start), .cmd(cmd), .param(param),
        .fail(fail), .fail_code(fail_code)
    );

    bus_sequencer u_bus_sequencer (
        .clock(clock), .rst_n(rst_n), .start(start), .cmd(cmd), .param(param),
        .done(done), .done_cmd(done_cmd), .read_word(read_word),
        .data_pins(data_pins), .addr_pins(addr_pins), .board_sel(board_sel),
        .rd(rd), .wr(wr), .level_shift_en(level_shift_en)
    );

    response_writer u_response_writer (
        .clock(clock), .rst_n(rst_n), .done(done), .done_cmd(done_cmd),
        .read_word(read_word), .fail(fail), .fail_code(fail_code), .tx_busy(tx_busy),
        .tx_start(tx_start), .tx_data(tx_data), .reply_busy(reply_busy)
    );

    uart_tx u_uart_tx (
        .clock(clock), .rst_n(rst_n), .tx_data(tx_data), .tx_start(tx_start),
        .tx_busy(tx_busy), .serial_out(uart_tx_pin)
    );

endmodule

// File: verif/pb_bridge_asserts.sv
module pb_bridge_asserts (
    input logic       clock,
    input logic       rst_n,
    input logic       rd,
    input logic       wr,
    input logic       data_dir,
    input logic [2:0] addr_pins
);
    timeunit 1ns;
    timeprecision 1ns;

    // No overlap and no direct turn from one strobe to the other
    strobe_excl: assert property (@(posedge clock) disable iff (!rst_n)
                                  !((rd || $past(rd)) && (wr || $past(wr))))
        else $error("rd and wr high together or back to back");

    // Port stays released through the read strobe and the cycle after it
    dir_on_read: assert property (@(posedge clock) disable iff (!rst_n)
                                  (rd || $past(rd)) |-> !data_dir)
        else $error("data_dir high during or right after a read strobe");

    // Address must hold across both strobe cycles
    addr_hold: assert property (@(posedge clock) disable iff (!rst_n)
                                ((rd || wr) && $past(rd || wr)) |-> $stable(addr_pins))
        else $error("addr_pins changed under a strobe");

endmodule

bind bus_sequencer pb_bridge_asserts u_asserts (
    .clock(clock), .rst_n(rst_n), .rd(rd), .wr(wr), .data_dir(data_dir),
    .addr_pins(addr_pins)
);

// File: verif/pb_bridge_tb.sv
module pb_bridge_tb;
    timeunit 1ns;
    timeprecision 1ns;

    logic       clock;
    logic       rst_n;
    logic       uart_rx_pin;
    wire        uart_tx_pin;
    wire  [7:0] data_pins;
    logic [2:0] addr_pins;
    logic [3:0] board_sel;
    logic       rd;
    logic       wr;
    logic       level_shift_en;

    logic [7:0] mem [16][8];    // Board model of 16 boards by 8 addresses
    int         errors;
    int         n_lines;
    string      cmds[$];
    string      exps[$];
    int         mem_b[$];
    int         mem_a[$];
    int         mem_v[$];

    pb_bridge_top UUT (
        .clock(clock), .rst_n(rst_n), .uart_rx_pin(uart_rx_pin), .uart_tx_pin(uart_tx_pin),
        .data_pins(data_pins), .addr_pins(addr_pins), .board_sel(board_sel),
        .rd(rd), .wr(wr), .level_shift_en(level_shift_en)
    );

    always #50 clock = ~clock;

    assign data_pins = rd ? mem[board_sel][addr_pins] : 'z;
    always @(negedge wr) mem[board_sel][addr_pins] <= data_pins;

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};                         // Stop, data, start
        for (int i = 0; i < 10; i++) begin
            @(posedge clock);
            uart_rx_pin <= frame[i];
            repeat (pb_pkg::clks_per_bit - 1) @(posedge clock);
        end
    endtask

    task automatic get_byte(output logic [7:0] b);
        do begin
            @(posedge clock);
        end while (uart_tx_pin !== 1'b0);
        repeat (pb_pkg::half_bit) @(posedge clock);      // Middle of start bit
        for (int i = 0; i < 8; i++) begin
            repeat (pb_pkg::clks_per_bit) @(posedge clock);
            b[i] = uart_tx_pin;
        end
        repeat (pb_pkg::clks_per_bit) @(posedge clock);
        if (uart_tx_pin !== 1'b1) begin
            errors++;
            $display("Reply frame at %0t has a low stop bit", $time);
        end
    endtask

    task automatic load_golden();
        int    fd;
        int    bar;
        int    b;
        int    a;
        int    v;
        string line;
        fd = $fopen("verif/pb_bridge_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open the golden file");
        end else begin
            while ($fgets(line, fd) != 0) begin
                while (line.len() > 0 && (line.getc(line.len() - 1) == 8'h0A ||
                                          line.getc(line.len() - 1) == 8'h0D)) begin
                    line = line.substr(0, line.len() - 2);
                end
                if (line.len() == 0 || line.getc(0) == "#") begin
                    continue;
                end
                if (line.getc(0) == "M") begin
                    void'($sscanf(line, "M %h %h %h", b, a, v));
                    mem_b.push_back(b);
                    mem_a.push_back(a);
                    mem_v.push_back(v);
                end else begin
                    bar = 0;
                    while (bar < line.len() && line.getc(bar) != "|") begin
                        bar++;
                    end
                    cmds.push_back(line.substr(0, bar - 1));
                    exps.push_back(line.substr(bar + 1, line.len() - 1));
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        string      reply;
        logic [7:0] c;
        clock       = 1'b0;
        rst_n       = 1'b0;
        uart_rx_pin = 1'b1;
        errors      = 0;
        for (int b = 0; b < 16; b++) begin
            for (int a = 0; a < 8; a++) begin
                mem[b][a] = 8'(b * 16 + a);
            end
        end
        load_golden();
        n_lines = cmds.size();
        repeat (8) @(posedge clock);
        rst_n <= 1'b1;
        repeat (4) @(posedge clock);
        if (level_shift_en !== 1'b1) begin
            errors++;
            $display("FAIL %0t level_shift_en exp 1 got %b", $time, level_shift_en);
        end
        foreach (cmds[t]) begin
            for (int i = 0; i < cmds[t].len(); i++) begin
                c = cmds[t].getc(i);
                send_byte(c == "*" ? pb_pkg::char_cr : c);   // Star stands for CR
            end
            send_byte(pb_pkg::char_lf);
            reply = "";
            do begin
                get_byte(c);
                reply = $sformatf("%s%c", reply, c);
            end while (c != pb_pkg::char_lf);
            if (reply != {exps[t], "\r\n"}) begin
                errors++;
                $display("FAIL %0t uart_tx_pin exp %s got %s", $time, exps[t], reply);
            end
        end
        foreach (mem_b[k]) begin
            if (mem[mem_b[k]][mem_a[k]] !== 8'(mem_v[k])) begin
                errors++;
                $display("FAIL %0t mem[%0d][%0d] exp %h got %h", $time, mem_b[k], mem_a[k],
                         8'(mem_v[k]), mem[mem_b[k]][mem_a[k]]);
            end
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Allows 60 characters of 10 bits per line plus 10 percent
    initial begin
        longint limit;
        wait (n_lines > 0);
        limit = longint'(n_lines) * 60 * 10 * pb_pkg::clks_per_bit * 100 * 11 / 10;
        #(limit);
        $display("Timeout, the replies did not finish within %0d ns", limit);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: verif/pb_bridge_golden.txt
# Columns: command|expected reply (CR LF implied); * in a command sends CR
# M board address value: expected model memory at the end, in hex
pb_i__read,07000000|pb_i__read,07000102
pb_i_write,0303A55A|pb_i_write,OK
pb_i__read,02030000|pb_i__read,32A55A35
pb_i__read,03020000|pb_i__read,23242526
pb_i_READ,00000000|Failed 0xFE
pb_i__read,0703ffff|pb_i__read,37303132
pb_i__read,0G000000|Failed 0xFD
pb_i_write,07fe1234*|pb_i_write,OK
pb_i__read,070e0000|pb_i__read,1234E1E2
M 3 3 A5
M 3 4 5A
M e 7 12
M e 0 34
M 0 7 07
M 2 0 20

// File: filelist.f
hw/pb_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/command_parser.sv
hw/bus_sequencer.sv
hw/response_writer.sv
hw/pb_bridge_top.sv
verif/pb_bridge_asserts.sv
verif/pb_bridge_tb.sv

// File: Makefile
TOP := pb_bridge_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
